// ==== source/sad_pkg.sv ====
// shared widths, counts and bus types for the self-attention engine
// input beat, Q/K/V buffer write and read requests, projected vectors
package sad_pkg;

    // ########################################################################
    // dimensions and widths
    // ########################################################################

    localparam int DIM      = 8;
    localparam int ELEMS    = 64;
    localparam int IN_BEATS = 192;
    localparam int DATA_W   = 8;
    // sum of eight 8x8 products
    localparam int PROJ_W   = 19;
    // sum of eight 19x19 products
    localparam int SCORE_W  = 41;
    // after relu and divide by three, unsigned
    localparam int SCALED_W = 40;
    localparam int OUT_W    = 63;
    localparam int ROWS_W   = 4;
    localparam int IDX_W    = 6;

    // ########################################################################
    // bus types
    // ########################################################################

    // one input beat
    typedef struct packed {
        logic                     valid;
        logic [ROWS_W-1:0]        rows;
        logic signed [DATA_W-1:0] x;
        logic signed [DATA_W-1:0] wq;
        logic signed [DATA_W-1:0] wk;
        logic signed [DATA_W-1:0] wv;
    } sad_in_t;

    typedef enum logic [1:0] {
        SEL_Q = 2'd0,
        SEL_K = 2'd1,
        SEL_V = 2'd2
    } qkv_sel_t;

    // one buffer write, idx is row-major
    typedef struct packed {
        logic              valid;
        qkv_sel_t          sel;
        logic [IDX_W-1:0]  idx;
        logic [PROJ_W-1:0] data;
    } qkv_wr_t;

    // row picks the Q row, col picks the K row and the V column
    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } qkv_rd_t;

    typedef logic [DIM-1:0][PROJ_W-1:0] proj_vec_t;

endpackage

// ==== source/sad_input_store.sv ====
// input store for the self-attention engine
// beat counter, token row count latch, X and weight capture,
// load_done pulse after the last beat
`timescale 1ns/1ps

module sad_input_store import sad_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  sad_in_t                      in_beat,
    output logic                         load_done,
    output logic [ROWS_W-1:0]            rows,
    output logic [ELEMS-1:0][DATA_W-1:0] x_mem,
    output logic [ELEMS-1:0][DATA_W-1:0] wq_mem,
    output logic [ELEMS-1:0][DATA_W-1:0] wk_mem,
    output logic [ELEMS-1:0][DATA_W-1:0] wv_mem
);

    logic [7:0]        beat_cnt;
    logic              first_beat;
    logic              last_beat;
    logic [ROWS_W-1:0] cur_rows;
    logic [7:0]        x_limit;
    logic [IDX_W-1:0]  elem;

    assign first_beat = in_beat.valid && (beat_cnt == 8'd0);
    assign last_beat  = in_beat.valid && (beat_cnt == 8'(IN_BEATS - 1));
    // T arrives with the first beat, later beats use the latched copy
    assign cur_rows   = first_beat ? in_beat.rows : rows;
    assign x_limit    = {1'b0, cur_rows, 3'b000};
    assign elem       = beat_cnt[IDX_W-1:0];

    // ########################################################################
    // beat counter and row count
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt  <= 8'd0;
            load_done <= 1'b0;
            rows      <= '0;
        end else begin
            load_done <= last_beat;
            if (last_beat) begin
                beat_cnt <= 8'd0;
            end else if (in_beat.valid) begin
                beat_cnt <= beat_cnt + 8'd1;
            end
            if (first_beat) begin
                rows <= in_beat.rows;
            end
        end
    end

    // ########################################################################
    // matrix capture
    // ########################################################################

    // X is wiped on a new job so rows at or beyond T read as zero
    always_ff @(posedge clk) begin
        if (first_beat) begin
            x_mem <= '0;
        end
        if (in_beat.valid && (beat_cnt[7:6] == 2'd0) && (beat_cnt < x_limit)) begin
            x_mem[elem] <= in_beat.x;
        end
    end

    // weights arrive one matrix per 64 beats, in Q, K, V order
    always_ff @(posedge clk) begin
        if (in_beat.valid) begin
            case (beat_cnt[7:6])
                2'd0:    wq_mem[elem] <= in_beat.wq;
                2'd1:    wk_mem[elem] <= in_beat.wk;
                default: wv_mem[elem] <= in_beat.wv;
            endcase
        end
    end

endmodule

// ==== source/sad_projection_engine.sv ====
// projection engine for Q = X*W_Q, K = X*W_K and V = X*W_V
// 192-step sequencer, eight-lane multiply stage, sum stage,
// buffer write port and proj_done pulse
`timescale 1ns/1ps

module sad_projection_engine import sad_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_done,
    input  logic [ELEMS-1:0][DATA_W-1:0] x_mem,
    input  logic [ELEMS-1:0][DATA_W-1:0] wq_mem,
    input  logic [ELEMS-1:0][DATA_W-1:0] wk_mem,
    input  logic [ELEMS-1:0][DATA_W-1:0] wv_mem,
    output qkv_wr_t                      wr,
    output logic                         proj_done
);

    logic [7:0]                   step;
    logic                         active;
    qkv_sel_t                     iss_sel;
    logic [2:0]                   iss_row;
    logic [2:0]                   iss_col;
    logic [ELEMS-1:0][DATA_W-1:0] w_mem;
    logic signed [2*DATA_W-1:0]   prod [DIM];
    logic                         p_valid;
    qkv_sel_t                     p_sel;
    logic [IDX_W-1:0]             p_idx;
    logic signed [PROJ_W-1:0]     lane_sum;
    logic                         wr_valid;
    qkv_sel_t                     wr_sel;
    logic [IDX_W-1:0]             wr_idx;
    logic [PROJ_W-1:0]            wr_data;

    // step[7:6] picks the matrix, then output row and column
    assign iss_sel = qkv_sel_t'(step[7:6]);
    assign iss_row = step[5:3];
    assign iss_col = step[2:0];

    always_comb begin
        case (iss_sel)
            SEL_K:   w_mem = wk_mem;
            SEL_V:   w_mem = wv_mem;
            default: w_mem = wq_mem;
        endcase
    end

    // ########################################################################
    // sequencer
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            step   <= 8'd0;
        end else if (load_done) begin
            active <= 1'b1;
            step   <= 8'd0;
        end else if (active) begin
            if (step == 8'(3 * ELEMS - 1)) begin
                active <= 1'b0;
                step   <= 8'd0;
            end else begin
                step <= step + 8'd1;
            end
        end
    end

    // ########################################################################
    // multiply and sum pipeline
    // ########################################################################

    // X row against weight column, the weight array is read transposed
    always_ff @(posedge clk) begin
        for (int l = 0; l < DIM; l++) begin
            prod[l] <= $signed(x_mem[iss_row * DIM + l]) * $signed(w_mem[l * DIM + iss_col]);
        end
        p_sel <= iss_sel;
        p_idx <= step[IDX_W-1:0];
    end

    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < DIM; l++) begin
            lane_sum = lane_sum + PROJ_W'(prod[l]);
        end
    end

    always_ff @(posedge clk) begin
        wr_sel  <= p_sel;
        wr_idx  <= p_idx;
        wr_data <= lane_sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p_valid   <= 1'b0;
            wr_valid  <= 1'b0;
            proj_done <= 1'b0;
        end else begin
            p_valid   <= active;
            wr_valid  <= p_valid;
            // last V element lands in the buffer at this edge
            proj_done <= wr_valid && (wr_sel == SEL_V) && (wr_idx == '1);
        end
    end

    assign wr = '{valid: wr_valid, sel: wr_sel, idx: wr_idx, data: wr_data};

endmodule

// ==== source/sad_qkv_buffer.sv ====
// Q/K/V register store
// three 64-entry arrays written through one steered port,
// combinational Q row, K row and transposed V column reads
`timescale 1ns/1ps

module sad_qkv_buffer import sad_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  qkv_wr_t   wr,
    input  qkv_rd_t   rd,
    output proj_vec_t q_row,
    output proj_vec_t k_row,
    output proj_vec_t v_col
);

    logic [PROJ_W-1:0] q_mem [ELEMS];
    logic [PROJ_W-1:0] k_mem [ELEMS];
    logic [PROJ_W-1:0] v_mem [ELEMS];

    // ########################################################################
    // write port
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ELEMS; i++) begin
                q_mem[i] <= '0;
                k_mem[i] <= '0;
                v_mem[i] <= '0;
            end
        end else if (wr.valid) begin
            case (wr.sel)
                SEL_Q:   q_mem[wr.idx] <= wr.data;
                SEL_K:   k_mem[wr.idx] <= wr.data;
                default: v_mem[wr.idx] <= wr.data;
            endcase
        end
    end

    // ########################################################################
    // read ports
    // ########################################################################

    // K is read by row so that Q*K^T needs no transpose,
    // V is gathered down a column from eight rows
    always_comb begin
        for (int c = 0; c < DIM; c++) begin
            q_row[c] = q_mem[rd.row * DIM + c];
            k_row[c] = k_mem[rd.col * DIM + c];
            v_col[c] = v_mem[c * DIM + rd.col];
        end
    end

endmodule

// ==== source/sad_attention_engine.sv ====
// attention engine
// score phase: Q*K^T, relu and divide by three into a local score array
// output phase: S*V, one element per cycle on out_data
`timescale 1ns/1ps

module sad_attention_engine import sad_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     proj_done,
    output qkv_rd_t                  rd,
    input  proj_vec_t                q_row,
    input  proj_vec_t                k_row,
    input  proj_vec_t                v_col,
    output logic                     out_valid,
    output logic signed [OUT_W-1:0]  out_data
);

    logic [IDX_W-1:0]                   cnt;
    logic                               score_active;
    logic                               out_active;
    logic                               score_last;
    logic signed [2*PROJ_W-1:0]         qk_prod [DIM];
    logic                               s1_valid;
    logic [IDX_W-1:0]                   s1_idx;
    logic signed [SCORE_W-1:0]          qk_sum;
    logic signed [SCORE_W-1:0]          s2_sum;
    logic                               s2_valid;
    logic [IDX_W-1:0]                   s2_idx;
    logic [SCALED_W-1:0]                relu_div;
    logic [SCALED_W-1:0]                score_mem [ELEMS];
    logic signed [SCALED_W+PROJ_W:0]    sv_prod [DIM];
    logic                               o1_valid;
    logic signed [OUT_W-1:0]            sv_sum;

    // both phases walk (row, col) in row-major order
    assign rd = '{row: cnt[5:3], col: cnt[2:0]};

    // last score is written at the end of this cycle
    assign score_last = s2_valid && (s2_idx == '1);

    // ########################################################################
    // phase control
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= '0;
            score_active <= 1'b0;
            out_active   <= 1'b0;
        end else begin
            if (proj_done) begin
                score_active <= 1'b1;
                cnt          <= '0;
            end else if (score_active || out_active) begin
                cnt <= cnt + 1'b1;
                if (cnt == '1) begin
                    score_active <= 1'b0;
                    out_active   <= 1'b0;
                end
            end
            // cnt has already wrapped to zero when the scores are complete
            if (score_last) begin
                out_active <= 1'b1;
            end
        end
    end

    // ########################################################################
    // score pipeline
    // ########################################################################

    always_ff @(posedge clk) begin
        for (int l = 0; l < DIM; l++) begin
            qk_prod[l] <= $signed(q_row[l]) * $signed(k_row[l]);
        end
        s1_idx <= cnt;
    end

    always_comb begin
        qk_sum = '0;
        for (int l = 0; l < DIM; l++) begin
            qk_sum = qk_sum + SCORE_W'(qk_prod[l]);
        end
    end

    always_ff @(posedge clk) begin
        s2_sum <= qk_sum;
        s2_idx <= s1_idx;
    end

    // clamp at zero, then divide; a positive value truncates like floor
    always_comb begin
        if (s2_sum[SCORE_W-1]) begin
            relu_div = '0;
        end else begin
            relu_div = s2_sum[SCALED_W-1:0] / SCALED_W'(3);
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            score_mem[s2_idx] <= relu_div;
        end
    end

    // ########################################################################
    // output pipeline
    // ########################################################################

    // scores are non-negative, a zero msb keeps the product signed
    always_ff @(posedge clk) begin
        for (int l = 0; l < DIM; l++) begin
            sv_prod[l] <= $signed({1'b0, score_mem[cnt[5:3] * DIM + l]}) * $signed(v_col[l]);
        end
    end

    always_comb begin
        sv_sum = '0;
        for (int l = 0; l < DIM; l++) begin
            sv_sum = sv_sum + OUT_W'(sv_prod[l]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            o1_valid  <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            s1_valid  <= score_active;
            s2_valid  <= s1_valid;
            o1_valid  <= out_active;
            out_valid <= o1_valid;
            // out_data idles at zero between results
            out_data  <= o1_valid ? sv_sum : '0;
        end
    end

endmodule

// ==== source/sad_attention_top.sv ====
// top level of the single-head self-attention engine
// input store, projection engine, Q/K/V buffer and attention engine
`timescale 1ns/1ps

module sad_attention_top import sad_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [ROWS_W-1:0]        T,
    input  logic signed [DATA_W-1:0] in_data,
    input  logic signed [DATA_W-1:0] w_q,
    input  logic signed [DATA_W-1:0] w_k,
    input  logic signed [DATA_W-1:0] w_v,
    output logic                     out_valid,
    output logic signed [OUT_W-1:0]  out_data
);

    sad_in_t                      in_beat;
    logic                         load_done;
    logic [ELEMS-1:0][DATA_W-1:0] x_mem;
    logic [ELEMS-1:0][DATA_W-1:0] wq_mem;
    logic [ELEMS-1:0][DATA_W-1:0] wk_mem;
    logic [ELEMS-1:0][DATA_W-1:0] wv_mem;
    qkv_wr_t                      wr;
    logic                         proj_done;
    qkv_rd_t                      rd;
    proj_vec_t                    q_row;
    proj_vec_t                    k_row;
    proj_vec_t                    v_col;

    assign in_beat = '{valid: in_valid, rows: T, x: in_data, wq: w_q, wk: w_k, wv: w_v};

    sad_input_store u_input_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .load_done (load_done),
        .rows      (),
        .x_mem     (x_mem),
        .wq_mem    (wq_mem),
        .wk_mem    (wk_mem),
        .wv_mem    (wv_mem)
    );

    sad_projection_engine u_projection_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_done (load_done),
        .x_mem     (x_mem),
        .wq_mem    (wq_mem),
        .wk_mem    (wk_mem),
        .wv_mem    (wv_mem),
        .wr        (wr),
        .proj_done (proj_done)
    );

    sad_qkv_buffer u_qkv_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .rd    (rd),
        .q_row (q_row),
        .k_row (k_row),
        .v_col (v_col)
    );

    sad_attention_engine u_attention_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .proj_done (proj_done),
        .rd        (rd),
        .q_row     (q_row),
        .k_row     (k_row),
        .v_col     (v_col),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== verif/sad_attention_tb.sv ====
// testbench for the single-head self-attention engine
// clock and reset, test table reader, input stimulus, output capture,
// checksum and element checks, timeout and summary
`timescale 1ns/1ps

module sad_attention_tb import sad_pkg::*; ();

    localparam int MAX_TESTS    = 16;
    localparam int TEST_CYCLES  = 800;
    localparam int RESET_CYCLES = 16;
    localparam int NAME_CHARS   = 24;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic [ROWS_W-1:0]        T;
    logic signed [DATA_W-1:0] in_data;
    logic signed [DATA_W-1:0] w_q;
    logic signed [DATA_W-1:0] w_k;
    logic signed [DATA_W-1:0] w_v;
    logic                     out_valid;
    logic signed [OUT_W-1:0]  out_data;

    // test table, base order is x, wq, wk, wv
    string                    t_name  [MAX_TESTS];
    int                       t_rows  [MAX_TESTS];
    int                       t_base  [MAX_TESTS][4];
    longint                   t_sum   [MAX_TESTS];
    longint                   t_out0  [MAX_TESTS];
    longint                   t_out63 [MAX_TESTS];
    int                       num_tests;

    logic signed [OUT_W-1:0]  got [ELEMS];
    int                       test_errs;
    int                       other_errs;
    int                       pass_cnt;
    int                       fail_cnt;
    int                       cycle_cnt = 0;
    int                       cycle_limit = TEST_CYCLES;

    sad_attention_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .T         (T),
        .in_data   (in_data),
        .w_q       (w_q),
        .w_k       (w_k),
        .w_v       (w_v),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ########################################################################
    // helpers
    // ########################################################################

    // element i of a stimulus matrix, wrapped to signed 8 bits
    function automatic logic signed [DATA_W-1:0] matrix_elem(input int base, input int i);
        matrix_elem = DATA_W'(base + 7 * i);
    endfunction

    task automatic load_tests();
        int                      fd;
        int                      code;
        string                   line;
        logic [8*NAME_CHARS-1:0] name;
        int                      rows;
        int                      bx;
        int                      bq;
        int                      bk;
        int                      bv;
        longint                  esum;
        longint                  e0;
        longint                  e63;
        num_tests = 0;
        fd = $fopen("verif/sad_attention_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/sad_attention_tests.txt");
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%s %d %d %d %d %d %d %d %d",
                                   name, rows, bx, bq, bk, bv, esum, e0, e63);
                    if (code == 9) begin
                        t_name[num_tests]    = string'(name);
                        t_rows[num_tests]    = rows;
                        t_base[num_tests][0] = bx;
                        t_base[num_tests][1] = bq;
                        t_base[num_tests][2] = bk;
                        t_base[num_tests][3] = bv;
                        t_sum[num_tests]     = esum;
                        t_out0[num_tests]    = e0;
                        t_out63[num_tests]   = e63;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // 192 input beats, out_valid must stay low meanwhile
    task automatic drive_job(input int n);
        for (int i = 0; i < IN_BEATS; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("%0s: out_valid was high during the input phase", t_name[n]);
                test_errs++;
            end
            in_valid = 1'b1;
            T        = ROWS_W'(t_rows[n]);
            in_data  = matrix_elem(t_base[n][0], i);
            w_q      = matrix_elem(t_base[n][1], i % ELEMS);
            w_k      = matrix_elem(t_base[n][2], i % ELEMS);
            w_v      = matrix_elem(t_base[n][3], i % ELEMS);
        end
        @(negedge clk);
        in_valid = 1'b0;
        T        = '0;
        in_data  = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
    endtask

    // outputs change on the rising edge, so they are sampled on the falling one
    task automatic capture_output(output int count);
        count = 0;
        while (out_valid !== 1'b1) begin
            @(negedge clk);
        end
        while (out_valid === 1'b1) begin
            if (count < ELEMS) begin
                got[count] = out_data;
            end
            count++;
            @(negedge clk);
        end
    endtask

    task automatic check_job(input int n, input int count);
        logic signed [OUT_W-1:0] sum;
        sum = '0;
        if (count != ELEMS) begin
            $display("%0s: output stream had %0d consecutive beats instead of %0d",
                     t_name[n], count, ELEMS);
            test_errs++;
        end
        for (int i = 0; i < ELEMS; i++) begin
            sum = sum + got[i];
        end
        if (sum != OUT_W'(t_sum[n])) begin
            $display("** Error: %0s checksum: expected %0d, actual %0d",
                     t_name[n], OUT_W'(t_sum[n]), sum);
            test_errs++;
        end
        if (got[0] != OUT_W'(t_out0[n])) begin
            $display("** Error: %0s out[0]: expected %0d, actual %0d",
                     t_name[n], t_out0[n], got[0]);
            test_errs++;
        end
        if (got[ELEMS-1] != OUT_W'(t_out63[n])) begin
            $display("** Error: %0s out[63]: expected %0d, actual %0d",
                     t_name[n], t_out63[n], got[ELEMS-1]);
            test_errs++;
        end
        // X rows at or beyond T are zero, so are those output rows
        for (int i = t_rows[n] * DIM; i < ELEMS; i++) begin
            if (got[i] != '0) begin
                $display("** Error: %0s out[%0d]: expected 0, actual %0d", t_name[n], i, got[i]);
                test_errs++;
            end
        end
    endtask

    // ########################################################################
    // main sequence
    // ########################################################################

    initial begin
        int count;
        void'($urandom(8896));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        T          = '0;
        in_data    = '0;
        w_q        = '0;
        w_k        = '0;
        w_v        = '0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        other_errs = 0;
        load_tests();
        cycle_limit = TEST_CYCLES * ((num_tests > 0) ? num_tests : 1);

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("out_valid was not low during reset");
                other_errs++;
            end
        end
        rst_n = 1'b1;

        if (num_tests == 0) begin
            $display("no tests were read from the test file");
            other_errs++;
        end else begin
            for (int n = 0; n < num_tests; n++) begin
                repeat ($urandom_range(5, 0)) @(negedge clk);
                test_errs = 0;
                drive_job(n);
                capture_output(count);
                check_job(n, count);
                if (test_errs == 0) begin
                    pass_cnt++;
                    $display("test %0s ok", t_name[n]);
                end else begin
                    fail_cnt++;
                    $display("test %0s failed with %0d errors", t_name[n], test_errs);
                end
            end
        end

        // no stray beats after the last job
        repeat (10) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("out_valid rose again after the last output stream");
                other_errs++;
            end
        end

        $display("tests run %0d, passed %0d, failed %0d", num_tests, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/sad_attention_tests.txt ====
# name T x_base wq_base wk_base wv_base exp_sum exp_out0 exp_out63
# element i of each matrix is base + 7*i wrapped to signed 8 bits, exp_sum covers all 64 outputs
self_qkv_t1 1 0 0 0 0 -227934926688 -56343465024 0
relu_neg_t1 1 0 0 -128 5 0 0 0
zero_rows_t0 0 17 3 -40 90 0 0 0
shift_qk_t1 1 0 -128 -128 0 -95894173536 -23704177728 0
relu_swap_t1 1 0 -128 0 77 0 0 0
self_qkv_rerun 1 0 0 0 0 -227934926688 -56343465024 0

// ==== sad_attention.f ====
source/sad_pkg.sv
source/sad_input_store.sv
source/sad_projection_engine.sv
source/sad_qkv_buffer.sv
source/sad_attention_engine.sv
source/sad_attention_top.sv
verif/sad_attention_tb.sv
